//--- verilog/lock_pkg.sv
package lock_pkg;

    // Keypad and display digit geometry
    localparam int DIGIT_W     = 4;
    localparam int CODE_DIGITS = 4;
    localparam int CODE_W      = CODE_DIGITS * DIGIT_W;
    localparam int DISP_DIGITS = 6;

    // Stored user codes
    localparam int CODE_SLOTS = 4;
    localparam int SLOT_W     = $clog2(CODE_SLOTS);

    // Special digit values
    localparam logic [DIGIT_W-1:0] DIGIT_BLANK = 4'hB;
    localparam logic [DIGIT_W-1:0] DIGIT_MARK  = 4'hA;
    localparam logic [DIGIT_W-1:0] KEY_TIMEOUT = 4'hE;  // Only meaningful in digit 0

    // Timing, in clock cycles
    localparam int DEBOUNCE_CYCLES   = 4;
    localparam int RELOCK_CYCLES     = 20;
    localparam int OPEN_ALARM_CYCLES = 30;
    localparam int LOCKOUT_CYCLES    = 40;

    // Failed entries before the keypad is locked out
    localparam int MAX_ATTEMPTS = 5;

    // Counter widths derived from the limits above
    localparam int DEB_W     = $clog2(DEBOUNCE_CYCLES + 1);    // Saturates at the limit
    localparam int RELOCK_W  = $clog2(RELOCK_CYCLES);
    localparam int ALARM_W   = $clog2(OPEN_ALARM_CYCLES + 1);  // Holds at the limit
    localparam int ATTEMPT_W = $clog2(MAX_ATTEMPTS + 1);
    localparam int LOCKOUT_W = $clog2(LOCKOUT_CYCLES);

    // One keypad word, seen either as digits or as a flat code
    typedef union packed {
        logic [CODE_DIGITS-1:0][DIGIT_W-1:0] digits;  // digits[0] carries the timeout marker
        logic [CODE_W-1:0]                   word;    // Compared as a whole against the slots
    } key_word_t;

endpackage

//--- verilog/button_debounce.sv
`timescale 1ns/1ps

module button_debounce import lock_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic inside_button,
    output logic press             // One cycle, on release of a long enough press
);

    logic [DEB_W-1:0] held_cnt;
    logic             held_long;

    assign held_long = (held_cnt == DEB_W'(DEBOUNCE_CYCLES));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_cnt <= '0;
            press    <= 1'b0;
        end else begin
            press <= 1'b0;
            if (inside_button) begin
                // Count while held, stop at the limit
                if (!held_long) begin
                    held_cnt <= held_cnt + 1'b1;
                end
            end else begin
                // Short presses are just bounces
                if (held_long) begin
                    press <= 1'b1;
                end
                held_cnt <= '0;
            end
        end
    end

endmodule

//--- verilog/code_checker.sv
`timescale 1ns/1ps

module code_checker import lock_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              prog_valid,
    input  logic [SLOT_W-1:0] prog_index,
    input  key_word_t         prog_code,
    input  logic              check_start,
    input  key_word_t         check_code,
    output logic              check_done,
    output logic              check_ok
);

    logic [CODE_W-1:0] slot_mem [CODE_SLOTS];
    logic [CODE_W-1:0] code_reg;
    logic [SLOT_W-1:0] slot_idx;
    logic              busy;
    logic              match;      // Sticky over the walk
    logic              slot_hit;

    // One slot compared per cycle
    assign slot_hit   = busy && (slot_mem[slot_idx] == code_reg);
    assign check_done = busy && (slot_idx == SLOT_W'(CODE_SLOTS - 1));
    assign check_ok   = check_done && (match || slot_hit);

    // Slot storage starts all-F, which never matches a valid entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CODE_SLOTS; i++) begin
                slot_mem[i] <= '1;
            end
        end else if (prog_valid) begin
            slot_mem[prog_index] <= prog_code.word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            slot_idx <= '0;
            match    <= 1'b0;
        end else if (busy) begin
            match    <= match || slot_hit;
            slot_idx <= slot_idx + 1'b1;
            if (check_done) begin
                busy <= 1'b0;                     // Last slot reached
            end
        end else if (check_start) begin
            busy     <= 1'b1;
            slot_idx <= '0;
            match    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (check_start && !busy) begin
            code_reg <= check_code.word;
        end
    end

endmodule

//--- verilog/attempt_guard.sv
`timescale 1ns/1ps

module attempt_guard import lock_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                attempt_fail,
    input  logic                                attempt_ok,
    output logic                                lockout,
    output logic [DISP_DIGITS-1:0][DIGIT_W-1:0] bcd_digits
);

    logic [ATTEMPT_W-1:0] fail_cnt;
    logic [LOCKOUT_W-1:0] lock_cnt;
    logic                 last_attempt;
    logic                 lock_expired;

    assign last_attempt = (fail_cnt == ATTEMPT_W'(MAX_ATTEMPTS - 1));
    assign lock_expired = (lock_cnt == LOCKOUT_W'(LOCKOUT_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fail_cnt <= '0;
            lock_cnt <= '0;
            lockout  <= 1'b0;
        end else if (lockout) begin
            // Keypad blocked until the timer runs out
            if (lock_expired) begin
                lockout  <= 1'b0;
                lock_cnt <= '0;
                fail_cnt <= '0;
            end else begin
                lock_cnt <= lock_cnt + 1'b1;
            end
        end else if (attempt_ok) begin
            fail_cnt <= '0;
        end else if (attempt_fail) begin
            fail_cnt <= fail_cnt + 1'b1;
            if (last_attempt) begin
                lockout  <= 1'b1;
                lock_cnt <= '0;
            end
        end
    end

    // One mark per failure from digit 0 up, full row while locked out
    always_comb begin
        for (int i = 0; i < DISP_DIGITS; i++) begin
            if (lockout || (i < int'(fail_cnt))) begin
                bcd_digits[i] = DIGIT_MARK;
            end else begin
                bcd_digits[i] = DIGIT_BLANK;
            end
        end
    end

endmodule

//--- verilog/door_fsm.sv
`timescale 1ns/1ps

module door_fsm import lock_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      door_open,
    input  logic      press,         // Debounced inside button
    input  logic      key_valid,
    input  key_word_t key_word,
    input  logic      check_done,
    input  logic      check_ok,
    input  logic      lockout,
    output logic      check_start,
    output key_word_t check_code,
    output logic      attempt_fail,
    output logic      attempt_ok,
    output logic      bolt,
    output logic      beep,
    output logic      keypad_en
);

    typedef enum logic [2:0] {
        INIT,     // Waiting for the door to be shut after reset
        CLOSED,   // Bolted, keypad live unless locked out
        CHECK,    // One code comparison in flight
        BEEP,     // Single beep for a keypad timeout
        AJAR,     // Bolt retracted, door still shut
        OPEN      // Door physically open
    } state_t;

    state_t              state;
    logic [RELOCK_W-1:0] relock_cnt;
    logic [ALARM_W-1:0]  alarm_cnt;
    logic                key_timeout;
    logic                key_bad;
    logic                key_accept;

    // Decode the keypad word digit by digit
    always_comb begin
        key_timeout = (key_word.digits[0] == KEY_TIMEOUT);
        key_bad     = 1'b0;
        for (int i = 0; i < CODE_DIGITS; i++) begin
            if (key_word.digits[i] > 4'd9) begin
                key_bad = 1'b1;
            end
        end
    end

    assign key_accept = key_valid && keypad_en;  // Keys outside CLOSED are dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= INIT;
            relock_cnt   <= '0;
            alarm_cnt    <= '0;
            check_start  <= 1'b0;
            attempt_fail <= 1'b0;
            attempt_ok   <= 1'b0;
        end else begin
            // Pulses default low
            check_start  <= 1'b0;
            attempt_fail <= 1'b0;
            attempt_ok   <= 1'b0;

            case (state)
                INIT: begin
                    if (!door_open) begin
                        state <= CLOSED;
                    end
                end

                CLOSED: begin
                    if (press) begin
                        state      <= AJAR;
                        relock_cnt <= '0;
                    end else if (key_accept && key_timeout) begin
                        state <= BEEP;
                    end else if (key_accept && !key_bad) begin
                        state       <= CHECK;
                        check_start <= 1'b1;
                    end
                end

                CHECK: begin
                    if (check_done && check_ok) begin
                        state      <= AJAR;
                        relock_cnt <= '0;
                        attempt_ok <= 1'b1;
                    end else if (check_done) begin
                        state        <= CLOSED;
                        attempt_fail <= 1'b1;
                    end
                end

                BEEP: begin
                    state <= CLOSED;
                end

                AJAR: begin
                    if (door_open) begin
                        state     <= OPEN;
                        alarm_cnt <= '0;
                    end else if (press) begin
                        state <= CLOSED;
                    end else if (relock_cnt == RELOCK_W'(RELOCK_CYCLES - 1)) begin
                        state <= CLOSED;                  // Auto relock
                    end else begin
                        relock_cnt <= relock_cnt + 1'b1;
                    end
                end

                OPEN: begin
                    if (!door_open) begin
                        state      <= AJAR;
                        relock_cnt <= '0;                 // Relock window starts over
                    end else if (alarm_cnt != ALARM_W'(OPEN_ALARM_CYCLES)) begin
                        alarm_cnt <= alarm_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // Code under test is held for the whole check
    always_ff @(posedge clk) begin
        if (key_accept && !key_timeout && !key_bad && !press) begin
            check_code <= key_word;
        end
    end

    // Lock outputs follow the state
    always_comb begin
        bolt      = 1'b0;
        beep      = 1'b0;
        keypad_en = 1'b0;
        case (state)
            CLOSED: begin
                bolt      = 1'b1;
                keypad_en = !lockout;
            end
            CHECK: begin
                bolt = 1'b1;
            end
            BEEP: begin
                bolt = 1'b1;
                beep = 1'b1;
            end
            OPEN: begin
                beep = (alarm_cnt == ALARM_W'(OPEN_ALARM_CYCLES));  // Door left open
            end
            default: begin
                bolt = 1'b0;    // INIT and AJAR keep the bolt retracted
            end
        endcase
    end

endmodule

//--- verilog/lock_top.sv
`timescale 1ns/1ps

module lock_top import lock_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                door_open,      // Contact sensor
    input  logic                                inside_button,
    input  logic                                key_valid,
    input  key_word_t                           key_word,
    input  logic                                prog_valid,
    input  logic [SLOT_W-1:0]                   prog_index,
    input  key_word_t                           prog_code,
    output logic                                bolt,           // High means locked
    output logic                                beep,
    output logic                                keypad_en,
    output logic [DISP_DIGITS-1:0][DIGIT_W-1:0] bcd_digits
);

    logic      press;
    logic      check_start;
    key_word_t check_code;
    logic      check_done;
    logic      check_ok;
    logic      attempt_fail;
    logic      attempt_ok;
    logic      lockout;

    button_debounce i_button_debounce (
        .clk           (clk),
        .rst           (rst),
        .inside_button (inside_button),
        .press         (press)
    );

    door_fsm i_door_fsm (
        .clk          (clk),
        .rst          (rst),
        .door_open    (door_open),
        .press        (press),
        .key_valid    (key_valid),
        .key_word     (key_word),
        .check_done   (check_done),
        .check_ok     (check_ok),
        .lockout      (lockout),
        .check_start  (check_start),
        .check_code   (check_code),
        .attempt_fail (attempt_fail),
        .attempt_ok   (attempt_ok),
        .bolt         (bolt),
        .beep         (beep),
        .keypad_en    (keypad_en)
    );

    code_checker i_code_checker (
        .clk         (clk),
        .rst         (rst),
        .prog_valid  (prog_valid),
        .prog_index  (prog_index),
        .prog_code   (prog_code),
        .check_start (check_start),
        .check_code  (check_code),
        .check_done  (check_done),
        .check_ok    (check_ok)
    );

    attempt_guard i_attempt_guard (
        .clk          (clk),
        .rst          (rst),
        .attempt_fail (attempt_fail),
        .attempt_ok   (attempt_ok),
        .lockout      (lockout),
        .bcd_digits   (bcd_digits)
    );

endmodule

//--- bench/lock_assert.sv
`timescale 1ns/1ps

module lock_assert (
    input logic clk,
    input logic rst,
    input logic door_open,
    input logic bolt,
    input logic beep,
    input logic keypad_en,
    input logic lockout,
    input logic check_start,
    input logic check_done
);

    logic check_busy;  // A code check is in flight

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            check_busy <= 1'b0;
        end else if (check_start) begin
            check_busy <= 1'b1;
        end else if (check_done) begin
            check_busy <= 1'b0;
        end
    end

    // Open-door alarm only sounds with the bolt retracted
    open_beep_unlocked: assert property (
        @(posedge clk) disable iff (rst) (beep && door_open) |-> !bolt
    ) else $error("Beep with the door open while the bolt is thrown");

    lockout_blocks_keys: assert property (
        @(posedge clk) disable iff (rst) lockout |-> !keypad_en
    ) else $error("Keypad enabled during lockout");

    // Only one request to the code checker at a time
    single_check: assert property (
        @(posedge clk) disable iff (rst) check_start |-> !check_busy
    ) else $error("New code check started before the previous one finished");

endmodule

//--- bench/lock_tb.sv
`timescale 1ns/1ps

module lock_tb import lock_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 1;      // Inputs move just after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int CHECK_WAIT   = CODE_SLOTS + 3;
    localparam int RELOCK_WAIT  = RELOCK_CYCLES + 3;
    localparam int RUN_CYCLES   = RESET_CYCLES + 12 * CHECK_WAIT + 4 * RELOCK_WAIT
                                + LOCKOUT_CYCLES + OPEN_ALARM_CYCLES
                                + 4 * DEBOUNCE_CYCLES + 100;

    // Output selectors for wait_until
    localparam int SIG_BOLT   = 0;
    localparam int SIG_BEEP   = 1;
    localparam int SIG_KEYPAD = 2;

    logic                                clk;
    logic                                rst;
    logic                                door_open;
    logic                                inside_button;
    logic                                key_valid;
    key_word_t                           key_word;
    logic                                prog_valid;
    logic [SLOT_W-1:0]                   prog_index;
    key_word_t                           prog_code;
    logic                                bolt;
    logic                                beep;
    logic                                keypad_en;
    logic [DISP_DIGITS-1:0][DIGIT_W-1:0] bcd_digits;

    key_word_t codes [CODE_SLOTS];
    key_word_t wrong_code;
    integer    seed = 68565;

    lock_top i_lock_top (
        .clk           (clk),
        .rst           (rst),
        .door_open     (door_open),
        .inside_button (inside_button),
        .key_valid     (key_valid),
        .key_word      (key_word),
        .prog_valid    (prog_valid),
        .prog_index    (prog_index),
        .prog_code     (prog_code),
        .bolt          (bolt),
        .beep          (beep),
        .keypad_en     (keypad_en),
        .bcd_digits    (bcd_digits)
    );

    bind door_fsm lock_assert i_lock_assert (
        .clk         (clk),
        .rst         (rst),
        .door_open   (door_open),
        .bolt        (bolt),
        .beep        (beep),
        .keypad_en   (keypad_en),
        .lockout     (lockout),
        .check_start (check_start),
        .check_done  (check_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at time %0t: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic step(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    function automatic logic probe(input int sig);
        case (sig)
            SIG_BOLT: return bolt;
            SIG_BEEP: return beep;
            default:  return keypad_en;
        endcase
    endfunction

    // Poll one output each cycle up to the bound
    task automatic wait_until(input int sig, input logic value, input int bound,
                              input string what);
        int waited;
        waited = 0;
        while (probe(sig) !== value) begin
            if (waited == bound) begin
                abort_run($sformatf("Timed out after %0d cycles waiting for %s", bound, what));
            end
            step(1);
            waited++;
        end
    endtask

    function automatic key_word_t random_code();
        key_word_t w;
        for (int i = 0; i < CODE_DIGITS; i++) begin
            w.digits[i] = DIGIT_W'({$random(seed)} % 10);  // Keep it a decimal digit
        end
        return w;
    endfunction

    function automatic logic is_stored(input key_word_t w);
        for (int i = 0; i < CODE_SLOTS; i++) begin
            if (codes[i] == w) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [DISP_DIGITS-1:0][DIGIT_W-1:0] expected_display(input int marks);
        logic [DISP_DIGITS-1:0][DIGIT_W-1:0] d;
        for (int i = 0; i < DISP_DIGITS; i++) begin
            d[i] = (i < marks) ? DIGIT_MARK : DIGIT_BLANK;
        end
        return d;
    endfunction

    task automatic program_slot(input int index, input key_word_t code);
        prog_valid = 1'b1;
        prog_index = SLOT_W'(index);
        prog_code  = code;
        step(1);
        prog_valid = 1'b0;
    endtask

    task automatic enter_key(input key_word_t w);
        key_valid = 1'b1;
        key_word  = w;
        step(1);
        key_valid = 1'b0;
    endtask

    task automatic hold_button(input int cycles);
        inside_button = 1'b1;
        step(cycles);
        inside_button = 1'b0;
    endtask

    // Bolt must stay thrown for the whole window
    task automatic expect_locked(input int cycles, input string what);
        repeat (cycles) begin
            check(32'(bolt), 1, what);
            step(1);
        end
    endtask

    task automatic reset_and_close();
        check(32'(bolt), 0, "bolt after reset");
        check(32'(beep), 0, "beep after reset");
        check(32'(keypad_en), 0, "keypad_en after reset");
        check(32'(bcd_digits), 32'(expected_display(0)), "display after reset");
        door_open = 1'b0;
        wait_until(SIG_BOLT, 1'b1, 2, "bolt once the door is shut");
        check(32'(keypad_en), 1, "keypad_en once the door is shut");
    endtask

    task automatic unlock_by_code();
        for (int i = 0; i < CODE_SLOTS; i++) begin
            codes[i] = random_code();
            program_slot(i, codes[i]);
        end
        wrong_code = random_code();
        while (is_stored(wrong_code)) begin
            wrong_code = random_code();
        end
        enter_key(codes[3]);
        wait_until(SIG_BOLT, 1'b0, CHECK_WAIT, "unlock by the slot 3 code");
        wait_until(SIG_BOLT, 1'b1, RELOCK_WAIT, "relock after the slot 3 code");
        enter_key(wrong_code);
        expect_locked(CHECK_WAIT, "bolt after a wrong code");
        check(32'(bcd_digits), 32'(expected_display(1)), "display after one wrong code");
        check(32'(keypad_en), 1, "keypad_en after one wrong code");
    endtask

    task automatic lockout_after_failures();
        enter_key(codes[0]);  // A good code clears the earlier mark
        wait_until(SIG_BOLT, 1'b0, CHECK_WAIT, "unlock by the slot 0 code");
        wait_until(SIG_BOLT, 1'b1, RELOCK_WAIT, "relock after the slot 0 code");
        check(32'(bcd_digits), 32'(expected_display(0)), "display after a good code");
        for (int n = 1; n <= MAX_ATTEMPTS; n++) begin
            enter_key(wrong_code);
            expect_locked(CHECK_WAIT, "bolt during failed attempts");
            if (n < MAX_ATTEMPTS) begin
                check(32'(bcd_digits), 32'(expected_display(n)), "marks after a failure");
                check(32'(keypad_en), 1, "keypad_en before lockout");
            end else begin
                check(32'(bcd_digits), 32'(expected_display(DISP_DIGITS)), "display in lockout");
                check(32'(keypad_en), 0, "keypad_en in lockout");
            end
        end
        enter_key(codes[1]);
        expect_locked(CHECK_WAIT, "bolt after a good code in lockout");
        check(32'(bcd_digits), 32'(expected_display(DISP_DIGITS)), "display late in lockout");
        wait_until(SIG_KEYPAD, 1'b1, LOCKOUT_CYCLES + 3, "end of lockout");
        check(32'(bcd_digits), 32'(expected_display(0)), "display after lockout");
    endtask

    task automatic timeout_and_bad_keys();
        key_word_t w;
        int        beeps;
        w.digits[0] = KEY_TIMEOUT;
        w.digits[1] = 4'd1;
        w.digits[2] = 4'd2;
        w.digits[3] = 4'd3;
        beeps       = 0;
        enter_key(w);
        repeat (CHECK_WAIT) begin
            if (beep) begin
                beeps++;
            end
            check(32'(bolt), 1, "bolt around a keypad timeout");
            step(1);
        end
        check(beeps, 1, "beep cycles for a keypad timeout");
        w.digits[0] = 4'd4;
        w.digits[1] = 4'hC;   // Not a decimal digit
        enter_key(w);
        repeat (CHECK_WAIT) begin
            check(32'(bolt), 1, "bolt after a word with digit C");
            check(32'(beep), 0, "beep after a word with digit C");
            check(32'(keypad_en), 1, "keypad_en after a word with digit C");
            step(1);
        end
        check(32'(bcd_digits), 32'(expected_display(0)), "display after a word with digit C");
    endtask

    task automatic button_unlock();
        hold_button(DEBOUNCE_CYCLES - 1);
        expect_locked(DEBOUNCE_CYCLES + 2, "bolt after a short press");
        hold_button(DEBOUNCE_CYCLES);
        wait_until(SIG_BOLT, 1'b0, 3, "unlock by a long press");
        wait_until(SIG_BOLT, 1'b1, RELOCK_WAIT, "relock after a press");
    endtask

    task automatic open_door_alarm();
        enter_key(codes[2]);
        wait_until(SIG_BOLT, 1'b0, CHECK_WAIT, "unlock by the slot 2 code");
        door_open = 1'b1;
        repeat (OPEN_ALARM_CYCLES) begin
            step(1);
            check(32'(beep), 0, "beep before the open alarm time");
            check(32'(bolt), 0, "bolt while the door is open");
        end
        wait_until(SIG_BEEP, 1'b1, 3, "open door alarm");
        door_open = 1'b0;
        step(1);
        check(32'(beep), 0, "beep after the door closed");
        check(32'(bolt), 0, "bolt right after the door closed");
        wait_until(SIG_BOLT, 1'b1, RELOCK_WAIT, "relock after the door closed");
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired, the simulation ran longer than all tests allow");
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        door_open     = 1'b1;   // Door starts open so the FSM waits in INIT
        inside_button = 1'b0;
        key_valid     = 1'b0;
        key_word      = '0;
        prog_valid    = 1'b0;
        prog_index    = '0;
        prog_code     = '0;
        step(RESET_CYCLES);
        rst = 1'b0;
        reset_and_close();
        unlock_by_code();
        lockout_after_failures();
        timeout_and_bad_keys();
        button_unlock();
        open_door_alarm();
        $display("test passed");
        $finish;
    end

endmodule

//--- list.f
verilog/lock_pkg.sv
verilog/button_debounce.sv
verilog/code_checker.sv
verilog/attempt_guard.sv
verilog/door_fsm.sv
verilog/lock_top.sv
bench/lock_assert.sv
bench/lock_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = lock_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
